//--- src/rvPipe_consts.svh
// codes must fit the ctrlWord_t field widths; memory depth is 2**DMEM_ADDR_BITS words
`ifndef RVPIPE_CONSTS_SVH
`define RVPIPE_CONSTS_SVH

// instruction classes
`define TYPE_LOAD   4'd0
`define TYPE_IMM    4'd1
`define TYPE_STORE  4'd2
`define TYPE_REG    4'd3
`define TYPE_LUI    4'd4
`define TYPE_AUIPC  4'd5
// empty pipeline slot
`define TYPE_BUBBLE 4'd9

// funct3 access widths for loads and stores
`define FUN3_BYTE   3'b000
`define FUN3_HALF   3'b001
`define FUN3_WORD   3'b010
`define FUN3_BYTEU  3'b100
`define FUN3_HALFU  3'b101

`define RF_REGS        32
`define DMEM_WORDS     128
`define DMEM_ADDR_BITS 7

`endif

//--- src/rvPipePkg.sv
// shared types only; ctrlWord_t is 23 bits with instType in the low bits
package rvPipePkg;

    // data and address word
    typedef logic [31:0] word_t;

    // register index
    typedef logic [4:0] regAddr_t;

    // instruction class, see TYPE_* codes
    typedef logic [3:0] instType_t;

    typedef logic [2:0] fun3_t;

    // function unit select, {funct3, funct7 bit 30}
    typedef logic [3:0] funSel_t;

    // control word carried down the pipeline
    // fields unused by a class are zero, so rs1/rs2 are safe to compare
    typedef struct packed {
        regAddr_t  rs2;
        regAddr_t  rs1;
        regAddr_t  rd;
        logic      fun7;
        fun3_t     fun3;
        instType_t instType;
    } ctrlWord_t;

endpackage

//--- src/functionUnit.sv
// purely combinational, no flags; shifts use operandB[4:0] and undefined selects add
`timescale 1ns/1ps

module functionUnit (
    input  rvPipePkg::word_t   operandA,
    input  rvPipePkg::word_t   operandB,
    input  rvPipePkg::funSel_t funSel,
    output rvPipePkg::word_t   result
);

    logic [4:0] shamt;

    assign shamt = operandB[4:0];

    // funSel is {funct3, funct7 bit 30}
    always_comb begin
        case (funSel)
            4'b0000: result = operandA + operandB;
            4'b0001: result = operandA - operandB;
            4'b0010: result = operandA << shamt;
            // signed compare
            4'b0100: result = {31'b0, $signed(operandA) < $signed(operandB)};
            4'b0110: result = {31'b0, operandA < operandB};
            4'b1000: result = operandA ^ operandB;
            4'b1010: result = operandA >> shamt;
            // arithmetic shift keeps the sign
            4'b1011: result = $signed(operandA) >>> shamt;
            4'b1100: result = operandA | operandB;
            4'b1110: result = operandA & operandB;
            default: result = operandA + operandB;
        endcase
    end

endmodule

//--- src/regFile.sv
// 32 x 32 registers, x0 hardwired to zero; a same-cycle write is visible on the read ports
`timescale 1ns/1ps
`include "rvPipe_consts.svh"

module regFile (
    input  logic                clk,
    input  logic                rst,
    input  rvPipePkg::regAddr_t rdAddr0,
    input  rvPipePkg::regAddr_t rdAddr1,
    input  rvPipePkg::regAddr_t wrAddr,
    input  rvPipePkg::word_t    wrData,
    input  logic                wrEn,
    output rvPipePkg::word_t    rdData0,
    output rvPipePkg::word_t    rdData1
);

    rvPipePkg::word_t regs [`RF_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RF_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // bypass covers the writeback three slots back
    assign rdData0 = (rdAddr0 == '0) ? '0 :
                     (wrEn && wrAddr == rdAddr0) ? wrData : regs[rdAddr0];
    assign rdData1 = (rdAddr1 == '0) ? '0 :
                     (wrEn && wrAddr == rdAddr1) ? wrData : regs[rdAddr1];

    assert property (@(posedge clk) disable iff (rst) regs[0] == '0)
        else $error("x0 holds a nonzero value");

endmodule

//--- src/dataMem.sv
// word-addressed, no reset, asynchronous read; store data sits in the low bits of wrData
`timescale 1ns/1ps
`include "rvPipe_consts.svh"

module dataMem (
    input  logic                        clk,
    input  logic [`DMEM_ADDR_BITS-1:0] addr,
    input  rvPipePkg::word_t            wrData,
    input  logic                        wrEn,
    input  logic [2:0]                  wrLanes,
    output rvPipePkg::word_t            rdData
);

    rvPipePkg::word_t mem [`DMEM_WORDS];

    assign rdData = mem[addr];

    // lane codes 000 word, 0h1 half h, 1bb byte bb
    always_ff @(posedge clk) begin
        if (wrEn) begin
            casez (wrLanes)
                3'b000: mem[addr] <= wrData;
                3'b0?1: begin
                    if (wrLanes[1]) begin
                        mem[addr][31:16] <= wrData[15:0];
                    end else begin
                        mem[addr][15:0] <= wrData[15:0];
                    end
                end
                3'b1??: mem[addr][{wrLanes[1:0], 3'b000} +: 8] <= wrData[7:0];
                default: mem[addr] <= mem[addr];
            endcase
        end
    end

    // the datapath only raises wrEn for in-range stores with a legal lane code
    assert property (@(posedge clk)
        wrEn |-> !$isunknown({addr, wrLanes}) && wrLanes != 3'b010)
        else $error("data memory write with bad address or lane code");

endmodule

//--- src/instDecode.sv
// RV32I ALU, load/store, lui and auipc only; other opcodes and instrValid low become bubbles
`timescale 1ns/1ps
`include "rvPipe_consts.svh"

module instDecode (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 instrValid,
    input  rvPipePkg::word_t     instr,
    output rvPipePkg::ctrlWord_t cwordId,
    output rvPipePkg::ctrlWord_t cwordEx,
    output rvPipePkg::ctrlWord_t cwordMem,
    output rvPipePkg::ctrlWord_t cwordWb,
    output rvPipePkg::word_t     immEx,
    output rvPipePkg::word_t     immMem,
    output rvPipePkg::word_t     pcEx
);

    localparam logic [6:0] opLoad  = 7'b0000011;
    localparam logic [6:0] opImm   = 7'b0010011;
    localparam logic [6:0] opStore = 7'b0100011;
    localparam logic [6:0] opReg   = 7'b0110011;
    localparam logic [6:0] opLui   = 7'b0110111;
    localparam logic [6:0] opAuipc = 7'b0010111;

    localparam rvPipePkg::ctrlWord_t bubbleWord = '{
        rs2: '0, rs1: '0, rd: '0, fun7: 1'b0, fun3: '0, instType: `TYPE_BUBBLE
    };

    rvPipePkg::word_t immI;
    rvPipePkg::word_t immS;
    rvPipePkg::word_t immU;
    rvPipePkg::word_t immId;
    rvPipePkg::word_t pc;

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immU = {instr[31:12], 12'b0};

    always_comb begin
        cwordId = bubbleWord;
        immId = '0;
        if (instrValid) begin
            cwordId.fun3 = instr[14:12];
            cwordId.rd = instr[11:7];
            cwordId.rs1 = instr[19:15];
            case (instr[6:0])
                opLoad: begin
                    cwordId.instType = `TYPE_LOAD;
                    immId = immI;
                end
                opImm: begin
                    cwordId.instType = `TYPE_IMM;
                    // only slli/srli/srai carry a real funct7 bit
                    cwordId.fun7 = (instr[13:12] == 2'b01) ? instr[30] : 1'b0;
                    immId = immI;
                end
                opStore: begin
                    cwordId.instType = `TYPE_STORE;
                    cwordId.rd = '0;
                    cwordId.rs2 = instr[24:20];
                    immId = immS;
                end
                opReg: begin
                    cwordId.instType = `TYPE_REG;
                    cwordId.fun7 = instr[30];
                    cwordId.rs2 = instr[24:20];
                end
                opLui, opAuipc: begin
                    cwordId.instType = (instr[5]) ? `TYPE_LUI : `TYPE_AUIPC;
                    cwordId.fun3 = '0;
                    cwordId.rs1 = '0;
                    immId = immU;
                end
                default: cwordId = bubbleWord;
            endcase
        end
    end

    // control state, flushed to bubbles on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            cwordEx <= bubbleWord;
            cwordMem <= bubbleWord;
            cwordWb <= bubbleWord;
            pc <= '0;
        end else begin
            cwordEx <= cwordId;
            cwordMem <= cwordEx;
            cwordWb <= cwordMem;
            if (instrValid) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // immediate and pc follow their instruction
    always_ff @(posedge clk) begin
        immEx <= immId;
        immMem <= immEx;
        pcEx <= pc;
    end

    assert property (@(posedge clk) disable iff (rst)
        !$isunknown(cwordEx.instType) && (cwordEx.instType inside {`TYPE_LOAD, `TYPE_IMM,
            `TYPE_STORE, `TYPE_REG, `TYPE_LUI, `TYPE_AUIPC, `TYPE_BUBBLE}))
        else $error("unknown instruction type in EX");

endmodule

//--- src/datapath.sv
// no load-use stall, so the next slot must not read a load's rd; stores out of range are dropped
`timescale 1ns/1ps
`include "rvPipe_consts.svh"

module datapath (
    input  logic                        clk,
    input  logic                        rst,
    input  rvPipePkg::ctrlWord_t        cwordId,
    input  rvPipePkg::ctrlWord_t        cwordEx,
    input  rvPipePkg::ctrlWord_t        cwordMem,
    input  rvPipePkg::ctrlWord_t        cwordWb,
    input  rvPipePkg::word_t            immEx,
    input  rvPipePkg::word_t            immMem,
    input  rvPipePkg::word_t            pcEx,
    output rvPipePkg::regAddr_t         rfRdAddr0,
    output rvPipePkg::regAddr_t         rfRdAddr1,
    output rvPipePkg::regAddr_t         rfWrAddr,
    input  rvPipePkg::word_t            rfRdData0,
    input  rvPipePkg::word_t            rfRdData1,
    output rvPipePkg::word_t            rfWrData,
    output logic                        rfWrEn,
    output logic [`DMEM_ADDR_BITS-1:0] memAddr,
    output rvPipePkg::word_t            memWrData,
    output logic                        memWrEn,
    output logic [2:0]                  memWrLanes,
    input  rvPipePkg::word_t            memRdData,
    output rvPipePkg::word_t            aluA,
    output rvPipePkg::word_t            aluB,
    output rvPipePkg::funSel_t          aluSel,
    input  rvPipePkg::word_t            aluResult,
    output logic                        wbValid,
    output rvPipePkg::regAddr_t         wbRd,
    output rvPipePkg::word_t            wbData
);

    // pipeline data registers
    rvPipePkg::word_t rs1Ex;
    rvPipePkg::word_t rs2Ex;
    rvPipePkg::word_t aluMem;
    rvPipePkg::word_t storeMem;
    rvPipePkg::word_t wbReg;

    rvPipePkg::word_t rs1Fwd;
    rvPipePkg::word_t rs2Fwd;
    rvPipePkg::word_t storeData;
    rvPipePkg::word_t loadData;
    rvPipePkg::word_t memResult;
    logic [15:0]      loadHalf;
    logic [7:0]       loadByte;
    logic [1:0]       byteOff;
    logic             inRange;
    logic             memFwdOk;
    logic             wbFwdOk;

    function automatic logic writesReg(input rvPipePkg::instType_t t);
        return t inside {`TYPE_LOAD, `TYPE_IMM, `TYPE_REG, `TYPE_LUI, `TYPE_AUIPC};
    endfunction

    // load data is not ready in MEM, hence no MEM forward for loads
    assign memFwdOk = writesReg(cwordMem.instType) && cwordMem.instType != `TYPE_LOAD
                      && cwordMem.rd != '0;
    assign wbFwdOk = writesReg(cwordWb.instType) && cwordWb.rd != '0;

    // MEM is younger than WB, so it wins
    always_comb begin
        if (memFwdOk && cwordMem.rd == cwordEx.rs1) begin
            rs1Fwd = aluMem;
        end else if (wbFwdOk && cwordWb.rd == cwordEx.rs1) begin
            rs1Fwd = wbReg;
        end else begin
            rs1Fwd = rs1Ex;
        end
        if (memFwdOk && cwordMem.rd == cwordEx.rs2) begin
            rs2Fwd = aluMem;
        end else if (wbFwdOk && cwordWb.rd == cwordEx.rs2) begin
            rs2Fwd = wbReg;
        end else begin
            rs2Fwd = rs2Ex;
        end
    end

    // operand and function select
    always_comb begin
        case (cwordEx.instType)
            `TYPE_AUIPC: aluA = pcEx;
            // lui passes the immediate through an add with zero
            `TYPE_LUI: aluA = '0;
            default: aluA = rs1Fwd;
        endcase
        aluB = (cwordEx.instType == `TYPE_REG) ? rs2Fwd : immEx;
        case (cwordEx.instType)
            `TYPE_REG, `TYPE_IMM: aluSel = {cwordEx.fun3, cwordEx.fun7};
            default: aluSel = 4'b0000;
        endcase
    end

    always_ff @(posedge clk) begin
        rs1Ex <= rfRdData0;
        rs2Ex <= rfRdData1;
        aluMem <= aluResult;
        storeMem <= rs2Fwd;
        wbReg <= memResult;
    end

    // memory stage
    assign byteOff = aluMem[1:0];
    assign inRange = aluMem[31:`DMEM_ADDR_BITS+2] == '0;
    assign memAddr = aluMem[`DMEM_ADDR_BITS+1:2];
    assign storeData = (wbFwdOk && cwordWb.rd == cwordMem.rs2) ? wbReg : storeMem;
    assign memWrData = storeData;
    assign memWrEn = cwordMem.instType == `TYPE_STORE && inRange;

    always_comb begin
        case (cwordMem.fun3)
            `FUN3_HALF: memWrLanes = {1'b0, byteOff[1], 1'b1};
            `FUN3_BYTE: memWrLanes = {1'b1, byteOff};
            default: memWrLanes = 3'b000;
        endcase
    end

    assign loadHalf = byteOff[1] ? memRdData[31:16] : memRdData[15:0];
    assign loadByte = memRdData[{byteOff, 3'b000} +: 8];

    always_comb begin
        case (cwordMem.fun3)
            `FUN3_BYTE: loadData = {{24{loadByte[7]}}, loadByte};
            `FUN3_BYTEU: loadData = {24'b0, loadByte};
            `FUN3_HALF: loadData = {{16{loadHalf[15]}}, loadHalf};
            `FUN3_HALFU: loadData = {16'b0, loadHalf};
            default: loadData = memRdData;
        endcase
        case (cwordMem.instType)
            `TYPE_LOAD: memResult = loadData;
            `TYPE_LUI: memResult = immMem;
            default: memResult = aluMem;
        endcase
    end

    // register file and trace
    assign rfRdAddr0 = cwordId.rs1;
    assign rfRdAddr1 = cwordId.rs2;
    assign rfWrAddr = cwordWb.rd;
    assign rfWrData = wbReg;
    assign rfWrEn = wbValid;
    assign wbValid = writesReg(cwordWb.instType);
    assign wbRd = cwordWb.rd;
    assign wbData = wbReg;

    // load-use hazard is not stalled, so it must never occur
    assert property (@(posedge clk) disable iff (rst)
        (cwordMem.instType == `TYPE_LOAD && cwordMem.rd != '0) |->
            (cwordEx.rs1 != cwordMem.rd && cwordEx.rs2 != cwordMem.rd))
        else $error("instruction after a load reads its destination");

    assert property (@(posedge clk) disable iff (rst)
        cwordMem.instType == `TYPE_STORE |-> inRange)
        else $error("store address beyond data memory");

endmodule

//--- src/rvPipeTop.sv
// no fetch and no branches; every accepted instruction retires three edges after it is sampled
`timescale 1ns/1ps
`include "rvPipe_consts.svh"

module rvPipeTop (
    input  logic                clk,
    input  logic                rst,
    input  logic                instrValid,
    input  rvPipePkg::word_t    instr,
    output logic                wbValid,
    output rvPipePkg::regAddr_t wbRd,
    output rvPipePkg::word_t    wbData
);

    rvPipePkg::ctrlWord_t        cwordId;
    rvPipePkg::ctrlWord_t        cwordEx;
    rvPipePkg::ctrlWord_t        cwordMem;
    rvPipePkg::ctrlWord_t        cwordWb;
    rvPipePkg::word_t            immEx;
    rvPipePkg::word_t            immMem;
    rvPipePkg::word_t            pcEx;
    rvPipePkg::regAddr_t         rfRdAddr0;
    rvPipePkg::regAddr_t         rfRdAddr1;
    rvPipePkg::regAddr_t         rfWrAddr;
    rvPipePkg::word_t            rfRdData0;
    rvPipePkg::word_t            rfRdData1;
    rvPipePkg::word_t            rfWrData;
    logic                        rfWrEn;
    logic [`DMEM_ADDR_BITS-1:0] memAddr;
    rvPipePkg::word_t            memWrData;
    logic                        memWrEn;
    logic [2:0]                  memWrLanes;
    rvPipePkg::word_t            memRdData;
    rvPipePkg::word_t            aluA;
    rvPipePkg::word_t            aluB;
    rvPipePkg::funSel_t          aluSel;
    rvPipePkg::word_t            aluResult;

    instDecode decoder_i (
        .clk(clk), .rst(rst), .instrValid(instrValid), .instr(instr),
        .cwordId(cwordId), .cwordEx(cwordEx), .cwordMem(cwordMem), .cwordWb(cwordWb),
        .immEx(immEx), .immMem(immMem), .pcEx(pcEx)
    );

    datapath datapath_i (
        .clk(clk), .rst(rst),
        .cwordId(cwordId), .cwordEx(cwordEx), .cwordMem(cwordMem), .cwordWb(cwordWb),
        .immEx(immEx), .immMem(immMem), .pcEx(pcEx),
        .rfRdAddr0(rfRdAddr0), .rfRdAddr1(rfRdAddr1), .rfWrAddr(rfWrAddr),
        .rfRdData0(rfRdData0), .rfRdData1(rfRdData1), .rfWrData(rfWrData), .rfWrEn(rfWrEn),
        .memAddr(memAddr), .memWrData(memWrData), .memWrEn(memWrEn),
        .memWrLanes(memWrLanes), .memRdData(memRdData),
        .aluA(aluA), .aluB(aluB), .aluSel(aluSel), .aluResult(aluResult),
        .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData)
    );

    functionUnit funit_i (
        .operandA(aluA), .operandB(aluB), .funSel(aluSel), .result(aluResult)
    );

    regFile regFile_i (
        .clk(clk), .rst(rst), .rdAddr0(rfRdAddr0), .rdAddr1(rfRdAddr1), .wrAddr(rfWrAddr),
        .wrData(rfWrData), .wrEn(rfWrEn), .rdData0(rfRdData0), .rdData1(rfRdData1)
    );

    dataMem dataMem_i (
        .clk(clk), .addr(memAddr), .wrData(memWrData), .wrEn(memWrEn),
        .wrLanes(memWrLanes), .rdData(memRdData)
    );

endmodule

//--- bench/rvPipeTb.sv
// programs never read a load's rd in the very next slot and keep stores inside the data memory
`timescale 1ns/1ps
`include "rvPipe_consts.svh"

module rvPipeTb;

    localparam logic [6:0] opImm = 7'b0010011;
    localparam logic [6:0] opLoad = 7'b0000011;
    localparam logic [6:0] opLui = 7'b0110111;
    localparam logic [6:0] opAuipc = 7'b0010111;

    // one expected trace port entry
    typedef struct packed {
        logic [4:0]       rd;
        rvPipePkg::word_t data;
        int               due;
    } retire_t;

    logic             clk;
    logic             rst;
    logic             instrValid;
    rvPipePkg::word_t instr;
    logic             wbValid;
    rvPipePkg::regAddr_t wbRd;
    rvPipePkg::word_t wbData;

    // architectural model
    rvPipePkg::word_t modelRegs [32];
    rvPipePkg::word_t modelMem [`DMEM_WORDS];
    rvPipePkg::word_t modelPc;

    retire_t expQ[$];
    int      edgeCount = 0;
    int      checkCount = 0;
    int      errorCount = 0;
    logic    watchOn = 1'b0;

    rvPipeTop dut_i (
        .clk(clk), .rst(rst), .instrValid(instrValid), .instr(instr),
        .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic checkEq(input rvPipePkg::word_t got, input rvPipePkg::word_t exp,
                           input string what);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("MISMATCH at %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // trace values are those held since the previous edge
    always @(posedge clk) begin : watchTrace
        retire_t e;
        edgeCount = edgeCount + 1;
        if (watchOn) begin
            if (expQ.size() > 0 && expQ[0].due == edgeCount) begin
                e = expQ.pop_front();
                checkEq({31'b0, wbValid}, 32'd1, "wbValid at a due retirement");
                checkEq({27'b0, wbRd}, {27'b0, e.rd}, "writeback rd");
                checkEq(wbData, e.data, $sformatf("writeback data for x%0d", e.rd));
            end else begin
                checkEq({31'b0, wbValid}, 32'd0, "wbValid with no retirement due");
            end
        end
    end

    function automatic rvPipePkg::word_t sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // RV32I integer op semantics
    function automatic rvPipePkg::word_t aluRef(input logic [2:0] f3, input logic alt,
                                                input rvPipePkg::word_t a,
                                                input rvPipePkg::word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic issue(input rvPipePkg::word_t w, input logic writes, input logic [4:0] rd,
                         input rvPipePkg::word_t val);
        retire_t e;
        @(negedge clk);
        instrValid = 1'b1;
        instr = w;
        modelPc = modelPc + 32'd4;
        if (writes) begin
            e.rd = rd;
            e.data = val;
            // sampled at edgeCount+1, visible in WB two edges later
            e.due = edgeCount + 4;
            expQ.push_back(e);
            if (rd != 5'd0) modelRegs[rd] = val;
        end
    endtask

    task automatic bubble(input int n);
        repeat (n) begin
            @(negedge clk);
            instrValid = 1'b0;
        end
    endtask

    task automatic doReg(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
        rvPipePkg::word_t val;
        val = aluRef(f3, alt, modelRegs[rs1], modelRegs[rs2]);
        issue({1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011}, 1'b1, rd, val);
    endtask

    task automatic doImm(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [11:0] imm);
        rvPipePkg::word_t val;
        logic alt;
        // only srai has an alternate form
        alt = (f3 == 3'd5) ? imm[10] : 1'b0;
        val = aluRef(f3, alt, modelRegs[rs1], sext12(imm));
        issue({imm, rs1, f3, rd, opImm}, 1'b1, rd, val);
    endtask

    task automatic doUpper(input logic isLui, input logic [4:0] rd, input logic [19:0] imm);
        rvPipePkg::word_t val;
        val = {imm, 12'b0};
        if (!isLui) val = val + modelPc;
        issue({imm, rd, isLui ? opLui : opAuipc}, 1'b1, rd, val);
    endtask

    task automatic doStore(input logic [2:0] f3, input logic [4:0] rs2, input logic [4:0] rs1,
                           input logic [11:0] imm);
        rvPipePkg::word_t addr;
        rvPipePkg::word_t d;
        logic [`DMEM_ADDR_BITS-1:0] wi;
        addr = modelRegs[rs1] + sext12(imm);
        d = modelRegs[rs2];
        wi = addr[`DMEM_ADDR_BITS+1:2];
        case (f3)
            `FUN3_BYTE: modelMem[wi][{addr[1:0], 3'b000} +: 8] = d[7:0];
            `FUN3_HALF: modelMem[wi][{addr[1], 4'b0000} +: 16] = d[15:0];
            default: modelMem[wi] = d;
        endcase
        issue({imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011}, 1'b0, 5'd0, '0);
    endtask

    task automatic doLoad(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [11:0] imm);
        rvPipePkg::word_t addr;
        rvPipePkg::word_t w;
        rvPipePkg::word_t val;
        logic [7:0] b;
        logic [15:0] h;
        addr = modelRegs[rs1] + sext12(imm);
        w = modelMem[addr[`DMEM_ADDR_BITS+1:2]];
        b = w[{addr[1:0], 3'b000} +: 8];
        h = w[{addr[1], 4'b0000} +: 16];
        case (f3)
            `FUN3_BYTE: val = {{24{b[7]}}, b};
            `FUN3_BYTEU: val = {24'b0, b};
            `FUN3_HALF: val = {{16{h[15]}}, h};
            `FUN3_HALFU: val = {16'b0, h};
            default: val = w;
        endcase
        issue({imm, rs1, f3, rd, opLoad}, 1'b1, rd, val);
        // independent filler so the next slot never reads rd
        doImm(3'd0, 5'd31, 5'd0, imm);
    endtask

    task automatic drain(input string name);
        int waited;
        waited = 0;
        @(negedge clk);
        instrValid = 1'b0;
        while (expQ.size() > 0 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (expQ.size() > 0) begin
            errorCount++;
            $display("timeout in %s: %0d expected writebacks never appeared", name, expQ.size());
            expQ.delete();
        end
    endtask

    task automatic finishTest(input string name, input int errStart);
        drain(name);
        $display("test %s finished with %0d errors", name, errorCount - errStart);
    endtask

    task automatic testReset();
        int errStart;
        errStart = errorCount;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            instrValid = 1'b0;
            // junk opcode bits must be ignored
            instr = $urandom;
            checkEq({31'b0, wbValid}, 32'd0, "wbValid while idle");
        end
        instr = '0;
        finishTest("reset and bubbles", errStart);
    endtask

    task automatic testRegOps();
        int errStart;
        errStart = errorCount;
        doImm(3'd0, 5'd1, 5'd0, 12'h123);
        doUpper(1'b1, 5'd2, 20'hF0F0F);
        doImm(3'd0, 5'd2, 5'd2, 12'h0A5);
        // x2 at distance one, x1 at distance three
        doReg(3'd0, 1'b0, 5'd3, 5'd1, 5'd2);
        doReg(3'd0, 1'b1, 5'd4, 5'd3, 5'd1);
        doImm(3'd0, 5'd5, 5'd0, 12'h007);
        doReg(3'd1, 1'b0, 5'd6, 5'd4, 5'd5);
        doReg(3'd5, 1'b1, 5'd7, 5'd2, 5'd5);
        doReg(3'd5, 1'b0, 5'd8, 5'd2, 5'd5);
        doReg(3'd2, 1'b0, 5'd9, 5'd7, 5'd6);
        doReg(3'd3, 1'b0, 5'd10, 5'd7, 5'd6);
        doReg(3'd4, 1'b0, 5'd11, 5'd9, 5'd2);
        doReg(3'd6, 1'b0, 5'd12, 5'd11, 5'd4);
        doReg(3'd7, 1'b0, 5'd13, 5'd12, 5'd11);
        doReg(3'd0, 1'b1, 5'd14, 5'd13, 5'd13);
        finishTest("register ops", errStart);
    endtask

    task automatic testImmOps();
        int errStart;
        errStart = errorCount;
        doImm(3'd0, 5'd5, 5'd0, 12'hFFF);
        doImm(3'd2, 5'd6, 5'd5, 12'h000);
        doImm(3'd3, 5'd7, 5'd5, 12'h7FF);
        doImm(3'd3, 5'd8, 5'd0, 12'h001);
        doImm(3'd4, 5'd9, 5'd5, 12'h555);
        doImm(3'd6, 5'd10, 5'd9, 12'h00F);
        doImm(3'd7, 5'd11, 5'd10, 12'h7F0);
        doUpper(1'b1, 5'd12, 20'h80000);
        doImm(3'd5, 5'd13, 5'd12, 12'h404);
        doImm(3'd5, 5'd14, 5'd12, 12'h004);
        doImm(3'd1, 5'd15, 5'd13, 12'h003);
        // pc holds still across bubbles
        doUpper(1'b0, 5'd16, 20'h00001);
        bubble(2);
        doUpper(1'b0, 5'd17, 20'h00000);
        bubble(1);
        doUpper(1'b0, 5'd18, 20'hFFFFF);
        doImm(3'd0, 5'd19, 5'd16, 12'hFFC);
        finishTest("immediate ops", errStart);
    endtask

    task automatic testMemory();
        int errStart;
        logic [7:0] byteVals [4];
        errStart = errorCount;
        byteVals = '{8'h5A, 8'h8B, 8'hBC, 8'hED};
        doImm(3'd0, 5'd20, 5'd0, 12'h100);
        doUpper(1'b1, 5'd21, 20'h89ABC);
        doImm(3'd0, 5'd21, 5'd21, 12'h5EF);
        // store data straight from the previous ALU result
        doStore(`FUN3_WORD, 5'd21, 5'd20, 12'd0);
        doImm(3'd0, 5'd22, 5'd21, 12'h111);
        doStore(`FUN3_WORD, 5'd22, 5'd20, 12'd4);
        doImm(3'd0, 5'd22, 5'd0, 12'h7A5);
        doStore(`FUN3_HALF, 5'd22, 5'd20, 12'd6);
        for (int off = 0; off < 4; off++) begin
            doImm(3'd0, 5'd23, 5'd0, {4'hF, byteVals[off]});
            doStore(`FUN3_BYTE, 5'd23, 5'd20, 12'(8 + off));
        end
        doImm(3'd0, 5'd24, 5'd0, 12'h7C3);
        doStore(`FUN3_HALF, 5'd24, 5'd20, 12'd12);
        doImm(3'd0, 5'd24, 5'd0, 12'hFC4);
        doStore(`FUN3_HALF, 5'd24, 5'd20, 12'd14);
        for (int a = 0; a < 16; a++) begin
            doLoad(`FUN3_BYTE, 5'd25, 5'd20, 12'(a));
            doLoad(`FUN3_BYTEU, 5'd26, 5'd20, 12'(a));
            if (a % 2 == 0) begin
                doLoad(`FUN3_HALF, 5'd27, 5'd20, 12'(a));
                doLoad(`FUN3_HALFU, 5'd28, 5'd20, 12'(a));
            end
            if (a % 4 == 0) begin
                doLoad(`FUN3_WORD, 5'd29, 5'd20, 12'(a));
            end
        end
        finishTest("loads and stores", errStart);
    endtask

    task automatic testRandom();
        int errStart;
        rvPipePkg::word_t r;
        rvPipePkg::word_t r2;
        logic [11:0] imm;
        errStart = errorCount;
        for (int n = 0; n < 80; n++) begin
            r = $urandom;
            r2 = $urandom;
            if (r[21:19] == 3'd0) bubble(1);
            if (r[22]) begin
                doReg(r[17:15], (r[17:15] == 3'd0 || r[17:15] == 3'd5) ? r[18] : 1'b0,
                      r[4:0], r[9:5], r[14:10]);
            end else begin
                imm = r2[11:0];
                if (r[17:15] == 3'd1) imm = {7'b0, r2[4:0]};
                else if (r[17:15] == 3'd5) imm = {1'b0, r[18], 5'b0, r2[4:0]};
                doImm(r[17:15], r[4:0], r[9:5], imm);
            end
        end
        finishTest("random ALU sequence", errStart);
    endtask

    initial begin
        void'($urandom(9));
        rst = 1'b1;
        instrValid = 1'b0;
        instr = '0;
        modelPc = '0;
        for (int i = 0; i < 32; i++) modelRegs[i] = '0;
        for (int i = 0; i < `DMEM_WORDS; i++) modelMem[i] = '0;
        // three rising edges with reset high
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        watchOn = 1'b1;
        testReset();
        testRegOps();
        testImmOps();
        testMemory();
        testRandom();
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- rvPipe.f
+incdir+src
src/rvPipePkg.sv
src/functionUnit.sv
src/regFile.sv
src/dataMem.sv
src/instDecode.sv
src/datapath.sv
src/rvPipeTop.sv
bench/rvPipeTb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module rvPipeTb -f rvPipe.f -o rvPipeSim
	./obj_dir/rvPipeSim 2>&1 | tee sim.log
	@if grep -q "Result: FAILED" sim.log; then exit 1; fi
	@grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
